/* common/video_timing_pkg.sv */
// Shared video timing types, mode table and register structs, imported by every RTL block

package video_timing_pkg;

    // ==========================================================
    // Basic types
    // ==========================================================

    typedef enum logic [1:0] {
        MODE_NTSC = 2'd0,   // 60 Hz colour
        MODE_PAL  = 2'd1,   // 50 Hz colour
        MODE_MONO = 2'd2    // 71 Hz monochrome
    } video_mode_e;

    typedef logic [6:0] hcount_t;  // Ticks within a line
    typedef logic [8:0] vcount_t;  // Lines within a frame

    // Limits of one mode, windows include start and exclude end
    typedef struct packed {
        hcount_t h_last;
        hcount_t hs_start;
        hcount_t hde_start;
        hcount_t hde_end;
        hcount_t hb_start;
        hcount_t hb_end;
        vcount_t v_last;
        vcount_t vs_start;
        vcount_t vde_start;
        vcount_t vde_end;
        vcount_t vb_start;
        vcount_t vb_end;
        logic    blank_en;
    } mode_timing_t;

    // ==========================================================
    // CPU side and output bundles
    // ==========================================================

    typedef enum logic {
        REG_SYNC = 1'b0,
        REG_MODE = 1'b1
    } reg_sel_e;

    typedef struct packed {
        logic       strobe;
        reg_sel_e   sel;
        logic [7:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic hsync_n;
        logic vsync_n;
        logic de;
        logic blank_n;
    } video_out_t;

    // One row per mode, monochrome has no blanking windows
    function automatic mode_timing_t mode_timing(input video_mode_e mode);
        mode_timing_t t;
        case (mode)
            MODE_PAL:  t = '{7'd127, 7'd118, 7'd16, 7'd96, 7'd9, 7'd114,
                             9'd312, 9'd310, 9'd62, 9'd262, 9'd24, 9'd307, 1'b1};
            MODE_MONO: t = '{7'd55, 7'd50, 7'd3, 7'd43, 7'd0, 7'd0,
                             9'd500, 9'd499, 9'd35, 9'd435, 9'd0, 9'd0, 1'b0};
            default:   t = '{7'd126, 7'd117, 7'd15, 7'd95, 7'd8, 7'd114,
                             9'd262, 9'd260, 9'd33, 9'd233, 9'd15, 9'd257, 1'b1};
        endcase
        return t;
    endfunction

endpackage

/* design/video_regs.sv */
// CPU-visible mode and sync byte registers with readback and requested mode encoding

`timescale 1ns/1ps

module video_regs (
    input  logic                          clk32,
    input  logic                          porb,
    input  video_timing_pkg::reg_wr_t     reg_wr_i,
    input  video_timing_pkg::reg_sel_e    rd_sel_i,
    output logic [7:0]                    rd_data_o,
    output video_timing_pkg::video_mode_e requested_mode_o
);
    import video_timing_pkg::*;

    logic mono_q;  // Mode register bit 1
    logic pal_q;   // Sync register bit 1

    // ==========================================================
    // Write side
    // ==========================================================

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            mono_q <= 1'b0;
            pal_q  <= 1'b0;
        end else if (reg_wr_i.strobe) begin
            case (reg_wr_i.sel)
                REG_MODE: mono_q <= reg_wr_i.data[1];
                REG_SYNC: pal_q  <= reg_wr_i.data[1];
                default:  ;
            endcase
        end
    end

    // ==========================================================
    // Readback and mode encoding
    // ==========================================================

    always_comb begin
        rd_data_o = 8'h00;  // Unused bits read as zero
        case (rd_sel_i)
            REG_MODE: rd_data_o[1] = mono_q;
            REG_SYNC: rd_data_o[1] = pal_q;
            default:  ;
        endcase
    end

    // Monochrome overrides the 50/60 Hz choice
    always_comb begin
        if (mono_q)
            requested_mode_o = MODE_MONO;
        else if (pal_q)
            requested_mode_o = MODE_PAL;
        else
            requested_mode_o = MODE_NTSC;
    end

endmodule

/* design/tick_timer.sv */
// Divides clk32 down to a single-cycle pixel tick enable for the raster counters

`timescale 1ns/1ps

module tick_timer #(
    parameter int TICK_DIV = 16
) (
    input  logic clk32,
    input  logic porb,
    output logic tick_o
);
    localparam int            CW   = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CW-1:0] TERM = CW'(TICK_DIV - 1);

    logic [CW-1:0] div_q;

    assign tick_o = (div_q == TERM);  // Terminal count

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb)
            div_q <= '0;
        else if (tick_o)
            div_q <= '0;
        else
            div_q <= div_q + CW'(1);
    end

    // Ticks are isolated pulses whenever the divider is real
    a_tick_single : assert property (
        @(posedge clk32) disable iff (!porb)
        (TICK_DIV > 1 && tick_o) |=> !tick_o
    ) else $error("tick_timer: tick high on two consecutive cycles");

endmodule

/* video/raster_counter.sv */
// Wrapping position counter, instantiated once for ticks per line and once for lines per frame

`timescale 1ns/1ps

module raster_counter #(
    parameter type count_t = logic [6:0]
) (
    input  logic   clk32,
    input  logic   porb,
    input  logic   step_i,
    input  count_t last_i,
    output count_t pos_o,
    output logic   wrap_o
);
    count_t pos_q;
    logic   at_last;

    // ==========================================================
    // Position register
    // ==========================================================

    // A shorter limit still wraps cleanly
    assign at_last = (pos_q >= last_i);
    assign wrap_o  = step_i && at_last;  // Same cycle as the return to 0
    assign pos_o   = pos_q;

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            pos_q <= '0;
        end else if (step_i) begin
            if (at_last)
                pos_q <= '0;
            else
                pos_q <= pos_q + count_t'(1);
        end
    end

    // Mode switches land on frame start, so the limit never drops below
    // the running position
    a_pos_in_range : assert property (
        @(posedge clk32) disable iff (!porb)
        pos_o <= last_i
    ) else $error("raster_counter: position %0d past last %0d", pos_o, last_i);

endmodule

/* video/frame_sequencer.sv */
// Frame level control FSM that owns the active mode, vertical windows and interrupt latches

`timescale 1ns/1ps

module frame_sequencer (
    input  logic                           clk32,
    input  logic                           porb,
    input  video_timing_pkg::video_mode_e  requested_mode_i,
    input  logic                           hwrap_i,
    input  logic                           vwrap_i,
    input  video_timing_pkg::vcount_t      vpos_i,
    input  logic                           hsync_start_i,
    input  logic                           hint_ack_i,
    input  logic                           vint_ack_i,
    output video_timing_pkg::mode_timing_t timing_o,
    output logic                           vde_o,
    output logic                           vunblank_o,
    output logic                           vsync_o,
    output logic                           ipl1_n_o,
    output logic                           ipl2_n_o
);
    import video_timing_pkg::*;

    typedef enum logic {
        STARTUP = 1'b0,
        SCAN    = 1'b1
    } seq_state_e;

    seq_state_e   state_q;
    video_mode_e  active_mode_q;
    mode_timing_t timing;
    logic         hint_q;
    logic         vint_q;
    logic         hint_set;
    logic         vint_set;

    // ==========================================================
    // State and mode latch
    // ==========================================================

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            state_q       <= STARTUP;
            active_mode_q <= MODE_NTSC;
        end else begin
            case (state_q)
                STARTUP: if (hwrap_i) state_q <= SCAN;  // First full line seen
                SCAN:    if (vwrap_i) active_mode_q <= requested_mode_i;
                default: state_q <= STARTUP;
            endcase
        end
    end

    assign timing   = mode_timing(active_mode_q);
    assign timing_o = timing;

    // Vertical windows
    assign vsync_o    = (vpos_i >= timing.vs_start);
    assign vde_o      = (vpos_i >= timing.vde_start) && (vpos_i < timing.vde_end);
    assign vunblank_o = !timing.blank_en ||
                        ((vpos_i >= timing.vb_start) && (vpos_i < timing.vb_end));

    // ==========================================================
    // Interrupt latches
    // ==========================================================

    assign hint_set = (state_q == SCAN) && hsync_start_i;
    assign vint_set = (state_q == SCAN) && hwrap_i && (vpos_i == timing.vs_start);

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hint_q <= 1'b0;
            vint_q <= 1'b0;
        end else begin
            if (hint_set)
                hint_q <= 1'b1;  // Set beats a simultaneous ack
            else if (hint_ack_i)
                hint_q <= 1'b0;
            if (vint_set)
                vint_q <= 1'b1;
            else if (vint_ack_i)
                vint_q <= 1'b0;
        end
    end

    assign ipl2_n_o = !vint_q;
    assign ipl1_n_o = !(hint_q && !vint_q);  // Masked by the higher level

    // Mode may only move at the frame boundary
    a_mode_on_vwrap : assert property (
        @(posedge clk32) disable iff (!porb)
        $changed(active_mode_q) |-> $past(vwrap_i)
    ) else $error("frame_sequencer: active mode changed outside a vertical wrap");

endmodule

/* video/sync_shaper.sv */
// Horizontal window decode and the registered sync, display enable and blank outputs

`timescale 1ns/1ps

module sync_shaper (
    input  logic                           clk32,
    input  logic                           porb,
    input  logic                           tick_i,
    input  video_timing_pkg::hcount_t      hpos_i,
    input  video_timing_pkg::mode_timing_t timing_i,
    input  logic                           vde_i,
    input  logic                           vunblank_i,
    input  logic                           vsync_i,
    output logic                           hsync_start_o,
    output video_timing_pkg::video_out_t   video_o
);
    import video_timing_pkg::*;

    logic       hsync_win;
    logic       hde_win;
    logic       hunblank_win;
    video_out_t video_q;

    // ==========================================================
    // Horizontal decode
    // ==========================================================

    assign hsync_win    = (hpos_i >= timing_i.hs_start);  // Runs to end of line
    assign hde_win      = (hpos_i >= timing_i.hde_start) && (hpos_i < timing_i.hde_end);
    assign hunblank_win = !timing_i.blank_en ||
                          ((hpos_i >= timing_i.hb_start) && (hpos_i < timing_i.hb_end));

    // Interrupt source, one pulse per line
    assign hsync_start_o = tick_i && (hpos_i == timing_i.hs_start);

    // ==========================================================
    // Output register
    // ==========================================================

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            video_q <= '{hsync_n: 1'b1, vsync_n: 1'b1, de: 1'b0, blank_n: 1'b1};
        end else begin
            video_q.hsync_n <= !hsync_win;
            video_q.vsync_n <= !vsync_i;
            video_q.de      <= hde_win && vde_i;
            video_q.blank_n <= hunblank_win && vunblank_i;
        end
    end

    assign video_o = video_q;

endmodule

/* design/gst_video_top.sv */
// Top level of the video timing core, connects the timer, registers, counters and decoders

`timescale 1ns/1ps

module gst_video_top #(
    parameter int TICK_DIV = 16  // clk32 cycles per pixel tick
) (
    input  logic                         clk32,
    input  logic                         porb,
    input  video_timing_pkg::reg_wr_t    reg_wr_i,
    input  video_timing_pkg::reg_sel_e   rd_sel_i,
    input  logic                         hint_ack_i,
    input  logic                         vint_ack_i,
    output logic [7:0]                   rd_data_o,
    output video_timing_pkg::video_out_t video_o,
    output logic                         ipl1_n_o,
    output logic                         ipl2_n_o
);
    import video_timing_pkg::*;

    logic         tick;
    video_mode_e  requested_mode;
    mode_timing_t timing;
    hcount_t      hpos;
    vcount_t      vpos;
    logic         hwrap;
    logic         vwrap;
    logic         vde;
    logic         vunblank;
    logic         vsync;
    logic         hsync_start;

    // ==========================================================
    // Clock enable and CPU registers
    // ==========================================================

    tick_timer #(.TICK_DIV(TICK_DIV)) i_tick (
        .clk32(clk32), .porb(porb), .tick_o(tick)
    );

    video_regs i_regs (
        .clk32(clk32), .porb(porb), .reg_wr_i(reg_wr_i), .rd_sel_i(rd_sel_i),
        .rd_data_o(rd_data_o), .requested_mode_o(requested_mode)
    );

    // ==========================================================
    // Raster
    // ==========================================================

    raster_counter #(.count_t(hcount_t)) i_hcnt (
        .clk32(clk32), .porb(porb), .step_i(tick), .last_i(timing.h_last),
        .pos_o(hpos), .wrap_o(hwrap)
    );

    raster_counter #(.count_t(vcount_t)) i_vcnt (  // Steps once per line
        .clk32(clk32), .porb(porb), .step_i(hwrap), .last_i(timing.v_last),
        .pos_o(vpos), .wrap_o(vwrap)
    );

    frame_sequencer i_seq (
        .clk32(clk32), .porb(porb), .requested_mode_i(requested_mode),
        .hwrap_i(hwrap), .vwrap_i(vwrap), .vpos_i(vpos), .hsync_start_i(hsync_start),
        .hint_ack_i(hint_ack_i), .vint_ack_i(vint_ack_i), .timing_o(timing),
        .vde_o(vde), .vunblank_o(vunblank), .vsync_o(vsync),
        .ipl1_n_o(ipl1_n_o), .ipl2_n_o(ipl2_n_o)
    );

    sync_shaper i_shaper (
        .clk32(clk32), .porb(porb), .tick_i(tick), .hpos_i(hpos), .timing_i(timing),
        .vde_i(vde), .vunblank_i(vunblank), .vsync_i(vsync),
        .hsync_start_o(hsync_start), .video_o(video_o)
    );

endmodule

/* testbench/video_checker.sv */
// Testbench monitor that measures raster intervals, checks readback and watches the interrupt lines

`timescale 1ns/1ps

module video_checker (
    input  logic                         clk32,
    input  logic                         porb,
    input  video_timing_pkg::video_out_t video_i,
    input  logic                         ipl1_n_i,
    input  logic                         ipl2_n_i,
    input  logic                         hint_ack_i,
    input  logic                         vint_ack_i,
    input  logic [7:0]                   rd_data_i,
    input  logic [1:0]                   cmd_i,      // 1 frame, 2 line, 3 readback
    input  int                           exp_line_i,
    input  int                           exp_hs_i,
    input  int                           exp_lines_i,
    input  int                           exp_vs_i,
    input  int                           exp_de_i,
    input  int                           exp_de_lines_i,
    input  logic [7:0]                   exp_rd_i,
    input  logic                         exp_mono_i,
    output logic                         done_o,
    output int                           errors_o
);
    int   run_err = 0;
    int   mon_err = 0;
    logic porb_q, hs_q, ipl2_q, hack_q, vack_q;

    assign errors_o = run_err + mon_err;

    task automatic fail_value(input string what, input int got, input int want);
        $display("Error %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        run_err++;
    endtask

    // ==========================================================
    // Measurements on command
    // ==========================================================

    // One frame from a vsync fall to the next
    task automatic measure_frame();
        int   cyc, lines, vs_lines, de_run, de_lines, hs_run, blank_lows, ipl2_falls;
        bit   first, bad_line, bad_de, bad_hs, bad_ipl1, ipl1_fell;
        logic vs_p, hs_p, ipl2_p, ipl1_p;
        vs_p = 1'b0;
        forever begin
            @(posedge clk32);
            if (vs_p && !video_i.vsync_n) break;
            vs_p = video_i.vsync_n;
        end
        {cyc, lines, vs_lines, de_run, de_lines, hs_run, blank_lows, ipl2_falls} = '0;
        {first, bad_line, bad_de, bad_hs, bad_ipl1, ipl1_fell} = 6'b100000;
        vs_p   = video_i.vsync_n;
        hs_p   = video_i.hsync_n;
        ipl2_p = ipl2_n_i;
        ipl1_p = ipl1_n_i;
        forever begin
            @(posedge clk32);
            cyc++;
            if (!video_i.hsync_n) hs_run++;
            if (video_i.de) de_run++;
            if (!video_i.blank_n) blank_lows++;
            if (ipl2_p && !ipl2_n_i) begin
                ipl2_falls++;
                if (video_i.vsync_n) fail_value("ipl2 fall outside vsync, vsync_n", 1, 0);
            end
            if (ipl1_p && !ipl1_n_i) ipl1_fell = 1'b1;  // Every line raises a hint
            if (hs_p && !video_i.hsync_n) begin  // Line boundary
                lines++;
                if (!video_i.vsync_n) vs_lines++;
                if (!first && cyc != exp_line_i && !bad_line) begin
                    bad_line = 1'b1;
                    fail_value("line period", cyc, exp_line_i);
                end
                if (!first && !ipl1_fell && !bad_ipl1) begin
                    bad_ipl1 = 1'b1;
                    fail_value("ipl1 falls in previous line", 0, 1);
                end
                if (de_run > 0) begin
                    de_lines++;
                    if (de_run != exp_de_i && !bad_de) begin
                        bad_de = 1'b1;
                        fail_value("DE cycles per line", de_run, exp_de_i);
                    end
                end
                {first, cyc, de_run, ipl1_fell} = '0;
            end
            if (!hs_p && video_i.hsync_n) begin
                if (hs_run != exp_hs_i && !bad_hs) begin
                    bad_hs = 1'b1;
                    fail_value("hsync low cycles", hs_run, exp_hs_i);
                end
                hs_run = 0;
            end
            if (vs_p && !video_i.vsync_n) break;  // Next frame start
            vs_p   = video_i.vsync_n;
            hs_p   = video_i.hsync_n;
            ipl2_p = ipl2_n_i;
            ipl1_p = ipl1_n_i;
        end
        if (lines != exp_lines_i) fail_value("lines per frame", lines, exp_lines_i);
        if (vs_lines != exp_vs_i) fail_value("vsync lines", vs_lines, exp_vs_i);
        if (de_lines != exp_de_lines_i) fail_value("DE lines", de_lines, exp_de_lines_i);
        if (exp_mono_i && blank_lows != 0) fail_value("mono blank_n low cycles", blank_lows, 0);
        if (ipl2_falls != 1) fail_value("ipl2 falls per frame", ipl2_falls, 1);
    endtask

    // Cycles between the next two hsync falls
    task automatic measure_line();
        int   cyc, falls;
        logic hs_p;
        {cyc, falls} = '0;
        hs_p = 1'b0;
        while (falls < 2) begin
            @(posedge clk32);
            cyc++;
            if (hs_p && !video_i.hsync_n) begin
                falls++;
                if (falls == 2 && cyc != exp_line_i) fail_value("old line period", cyc, exp_line_i);
                cyc = 0;
            end
            hs_p = video_i.hsync_n;
        end
    endtask

    initial begin
        done_o = 1'b0;
        forever begin
            @(posedge clk32);
            if (done_o) begin
                if (cmd_i == 2'd0) done_o = 1'b0;
            end else if (cmd_i != 2'd0) begin
                case (cmd_i)
                    2'd1:    measure_frame();
                    2'd2:    measure_line();
                    default: begin
                        if (rd_data_i != exp_rd_i)
                            fail_value("readback", int'(rd_data_i), int'(exp_rd_i));
                    end
                endcase
                done_o = 1'b1;
            end
        end
    end

    // ==========================================================
    // Reset levels and interrupt lines on every cycle
    // ==========================================================

    always @(posedge clk32) begin
        porb_q <= porb;
        hs_q   <= video_i.hsync_n;
        ipl2_q <= ipl2_n_i;
        hack_q <= hint_ack_i;
        vack_q <= vint_ack_i;
        if (porb && !porb_q && (video_i !== 4'b1101 || !ipl1_n_i || !ipl2_n_i)) begin
            $display("Error %0t ns: outputs not at reset levels after reset", $time);
            mon_err++;
        end
        if (porb && porb_q) begin
            if (!ipl1_n_i && !ipl2_n_i) begin
                $display("Error %0t ns: ipl1 and ipl2 low together", $time);
                mon_err++;
            end
            // A new hsync start on the ack edge keeps the level low
            if (hack_q && !ipl1_n_i && !(hs_q && !video_i.hsync_n)) begin
                $display("Error %0t ns: ipl1 still low after hint ack", $time);
                mon_err++;
            end
            if (vack_q && !ipl2_n_i) begin
                $display("Error %0t ns: ipl2 still low after vint ack", $time);
                mon_err++;
            end
            if (!ipl2_q && ipl2_n_i && !vack_q) begin
                $display("Error %0t ns: ipl2 released without vint ack", $time);
                mon_err++;
            end
        end
    end

endmodule

/* testbench/tb_video_top.sv */
// Testbench top for the video timing core, applies the mode table and reports the result

`timescale 1ns/1ps

module tb_video_top;
    import video_timing_pkg::*;

    localparam int DIV   = 4;
    localparam int NROWS = 4;

    typedef struct {
        string      name;
        logic [7:0] mode_b;
        logic [7:0] sync_b;
        int         line_cyc;
        int         hs_cyc;
        int         lines;
        int         vs_lines;
        int         de_cyc;
        int         de_lines;
        logic       mono;
    } row_t;

    logic       clk32, porb, hint_ack, vint_ack, ipl1_n, ipl2_n, done, exp_mono;
    reg_wr_t    reg_wr;
    reg_sel_e   rd_sel;
    logic [7:0] rd_data, exp_rd;
    video_out_t video;
    logic [1:0] cmd;
    int         exp_line, exp_hs, exp_lines, exp_vs, exp_de, exp_de_lines, errors;
    row_t       rows[NROWS];
    int         wd_limit = 0;
    logic [31:0] rnd = 32'hf9ee2d32;

    gst_video_top #(.TICK_DIV(DIV)) i_dut (
        .clk32(clk32), .porb(porb), .reg_wr_i(reg_wr), .rd_sel_i(rd_sel),
        .hint_ack_i(hint_ack), .vint_ack_i(vint_ack), .rd_data_o(rd_data),
        .video_o(video), .ipl1_n_o(ipl1_n), .ipl2_n_o(ipl2_n)
    );

    video_checker i_chk (
        .clk32(clk32), .porb(porb), .video_i(video), .ipl1_n_i(ipl1_n), .ipl2_n_i(ipl2_n),
        .hint_ack_i(hint_ack), .vint_ack_i(vint_ack), .rd_data_i(rd_data), .cmd_i(cmd),
        .exp_line_i(exp_line), .exp_hs_i(exp_hs), .exp_lines_i(exp_lines), .exp_vs_i(exp_vs),
        .exp_de_i(exp_de), .exp_de_lines_i(exp_de_lines), .exp_rd_i(exp_rd),
        .exp_mono_i(exp_mono), .done_o(done), .errors_o(errors)
    );

    always #2 clk32 = ~clk32;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    // Table entries in ticks and lines, scaled to clk32 cycles here
    task automatic set_row(input int i, input string nm, input logic [7:0] m, input logic [7:0] s,
                           input int tk, input int hs, input int ln, input int vs,
                           input int de, input int dl, input logic mono);
        rows[i] = '{nm, m, s, tk * DIV, hs * DIV, ln, vs, de * DIV, dl, mono};
    endtask

    task automatic run_check(input logic [1:0] c);
        @(posedge clk32);
        #0.5 cmd = c;
        do begin
            @(posedge clk32);
            #0.5;
        end while (!done);
        cmd = 2'd0;
        do begin
            @(posedge clk32);
            #0.5;
        end while (done);
    endtask

    task automatic write_reg(input reg_sel_e sel, input logic [7:0] d);
        @(posedge clk32);
        #0.5 reg_wr = '{strobe: 1'b1, sel: sel, data: d};
        @(posedge clk32);
        #0.5 reg_wr.strobe = 1'b0;
    endtask

    task automatic read_reg(input reg_sel_e sel, input logic [7:0] want);
        rd_sel = sel;
        exp_rd = want;
        run_check(2'd3);
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================

    initial begin
        int prev_line, err0, failed;
        clk32  = 1'b0;
        porb   = 1'b0;
        reg_wr = '0;
        rd_sel = REG_SYNC;
        cmd    = 2'd0;
        {exp_line, exp_hs, exp_lines, exp_vs, exp_de, exp_de_lines} = '0;
        exp_rd   = 8'h00;
        exp_mono = 1'b0;
        set_row(0, "NTSC", 8'h00, 8'h00, 127, 10, 263, 3, 80, 200, 1'b0);
        set_row(1, "PAL",  8'h00, 8'hfe, 128, 10, 313, 3, 80, 200, 1'b0);
        set_row(2, "MONO", 8'hf3, 8'h02,  56,  6, 501, 2, 40, 400, 1'b1);
        set_row(3, "NTSC", 8'h00, 8'h00, 127, 10, 263, 3, 80, 200, 1'b0);
        for (int i = 0; i < NROWS; i++) wd_limit += rows[i].line_cyc * rows[i].lines * 3;
        wd_limit += 20000;
        repeat (3) @(posedge clk32);
        #0.5 porb = 1'b1;

        failed = 0;
        read_reg(REG_MODE, 8'h00);
        read_reg(REG_SYNC, 8'h00);
        $display("Test 0 reset: %s", (errors == 0) ? "ok" : "wrong");
        if (errors != 0) failed++;
        prev_line = rows[0].line_cyc;  // Reset mode is NTSC

        for (int i = 0; i < NROWS; i++) begin
            err0 = errors;
            write_reg(REG_MODE, rows[i].mode_b);
            write_reg(REG_SYNC, rows[i].sync_b);
            read_reg(REG_MODE, rows[i].mode_b & 8'h02);  // Only bit 1 is stored
            read_reg(REG_SYNC, rows[i].sync_b & 8'h02);
            exp_line = prev_line;
            run_check(2'd2);  // Frame in progress keeps its line length
            exp_line     = rows[i].line_cyc;
            exp_hs       = rows[i].hs_cyc;
            exp_lines    = rows[i].lines;
            exp_vs       = rows[i].vs_lines;
            exp_de       = rows[i].de_cyc;
            exp_de_lines = rows[i].de_lines;
            exp_mono     = rows[i].mono;
            run_check(2'd1);
            prev_line = rows[i].line_cyc;
            $display("Test %0d %s: %s", i + 1, rows[i].name, (errors == err0) ? "ok" : "wrong");
            if (errors != err0) failed++;
        end

        $display("%0d tests, %0d failed, %0d errors", NROWS + 1, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Acknowledge pending interrupts after a random delay, vertical first
    initial begin
        int d;
        hint_ack = 1'b0;
        vint_ack = 1'b0;
        forever begin
            @(posedge clk32);
            #0.5;
            if (porb && (!ipl2_n || !ipl1_n)) begin
                rnd = xorshift(rnd);
                d   = int'(rnd % 32) + 1;
                repeat (d) @(posedge clk32);
                #0.5;
                if (!ipl2_n) vint_ack = 1'b1;
                else         hint_ack = 1'b1;
                @(posedge clk32);
                #0.5;
                vint_ack = 1'b0;
                hint_ack = 1'b0;
            end
        end
    end

    // Watchdog
    initial begin
        wait (wd_limit > 0);
        repeat (wd_limit) @(posedge clk32);
        $display("Timeout: the tests did not finish within %0d clock cycles", wd_limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* src.f */
common/video_timing_pkg.sv
design/video_regs.sv
design/tick_timer.sv
video/raster_counter.sv
video/frame_sequencer.sv
video/sync_shaper.sv
design/gst_video_top.sv
testbench/video_checker.sv
testbench/tb_video_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_video_top
FILELIST  = src.f
SIM       = obj_dir/$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
